//--- l1_consts.svh
`ifndef L1_CONSTS_SVH
`define L1_CONSTS_SVH

// address and data widths
`define L1_ADDR_WID 32
`define L1_DATA_WID 32

// address split into tag, index and offset
`define L1_OFFSET_WID 2
`define L1_INDEX_WID 4
`define L1_TAG_WID 26

// direct-mapped with one word per line
`define L1_LINES 16

`endif

//--- cache_pkg.sv
package cache_pkg;

`include "l1_consts.svh"

    typedef enum logic [1:0] {
        INVALID   = 2'd0,
        SHARED    = 2'd1,
        EXCLUSIVE = 2'd2,
        MODIFIED  = 2'd3
    } mesi_e;

    typedef struct packed {
        logic [`L1_TAG_WID-1:0]    tag;
        logic [`L1_INDEX_WID-1:0]  index;
        logic [`L1_OFFSET_WID-1:0] offset;
    } l1_addr_fields_t;

    // whole word on the buses, fields for lookup
    typedef union packed {
        logic [`L1_ADDR_WID-1:0] raw;
        l1_addr_fields_t         f;
    } l1_addr_t;

    typedef struct packed {
        logic [`L1_TAG_WID-1:0]  tag;
        mesi_e                   state;
        logic [`L1_DATA_WID-1:0] data;
    } l1_line_t;

    typedef struct packed {
        logic                    en;
        logic [`L1_INDEX_WID-1:0] index;
        l1_line_t                line;
    } line_wr_t;

endpackage

//--- bus_pkg.sv
package bus_pkg;

`include "l1_consts.svh"

    import cache_pkg::*;

    typedef struct packed {
        logic                    rd;
        logic                    wr;
        l1_addr_t                addr;
        logic [`L1_DATA_WID-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                    rd_done;
        logic                    wr_done;
        logic [`L1_DATA_WID-1:0] rdata;
    } cpu_rsp_t;

    // ========================================
    // level-2 bus
    // ========================================
    typedef struct packed {
        logic                    rd;
        logic                    rdx;
        logic                    wr;
        logic                    inv;
        l1_addr_t                addr;
        logic [`L1_DATA_WID-1:0] wdata;
    } l2_req_t;

    typedef struct packed {
        logic                    data_valid;
        logic                    shared;
        logic [`L1_DATA_WID-1:0] rdata;
        logic                    wr_done;
    } l2_rsp_t;

    // ========================================
    // snoop port
    // ========================================
    typedef struct packed {
        logic     rd;
        logic     rdx;
        logic     inv;
        l1_addr_t addr;
    } snoop_req_t;

    typedef struct packed {
        logic done;
        logic cp_in_cache;
        logic shared_local;
    } snoop_rsp_t;

endpackage

//--- l1_line_store.sv
`timescale 1ns/1ps

`include "l1_consts.svh"

module l1_line_store
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`L1_INDEX_WID-1:0] proc_index,
    output l1_line_t                 proc_line,
    input  logic [`L1_INDEX_WID-1:0] snoop_index,
    output l1_line_t                 snoop_line,
    input  line_wr_t                 wr
);

    logic [`L1_TAG_WID-1:0]  tag_mem  [`L1_LINES];
    logic [`L1_DATA_WID-1:0] data_mem [`L1_LINES];
    mesi_e                   state_q  [`L1_LINES];

    // state array is cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `L1_LINES; i++) begin
                state_q[i] <= INVALID;
            end
        end else if (wr.en) begin
            state_q[wr.index] <= wr.line.state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_mem[wr.index]  <= wr.line.tag;
            data_mem[wr.index] <= wr.line.data;
        end
    end

    // two combinational read ports
    always_comb begin
        proc_line.tag    = tag_mem[proc_index];
        proc_line.state  = state_q[proc_index];
        proc_line.data   = data_mem[proc_index];
    end

    always_comb begin
        snoop_line.tag   = tag_mem[snoop_index];
        snoop_line.state = state_q[snoop_index];
        snoop_line.data  = data_mem[snoop_index];
    end

endmodule

//--- l1_proc_ctrl.sv
`timescale 1ns/1ps

module l1_proc_ctrl
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    input  l1_line_t line,
    output logic     bus_req,
    input  logic     bus_gnt,
    output l2_req_t  l2_req,
    input  l2_rsp_t  l2_rsp,
    input  logic     all_invalidation_done,
    output line_wr_t line_wr
);

    typedef enum logic [2:0] {
        P_IDLE, P_REQ, P_WB, P_FILL, P_INV, P_WRITE, P_DONE
    } proc_state_e;

    proc_state_e state;
    logic        hit;

    assign hit = (line.tag == cpu_req.addr.f.tag) && (line.state != INVALID);

    // ========================================
    // bus and store requests
    // ========================================
    always_comb begin
        bus_req            = state inside {P_REQ, P_WB, P_FILL, P_INV, P_WRITE};
        l2_req             = '0;
        line_wr            = '0;
        line_wr.index      = cpu_req.addr.f.index;
        line_wr.line.tag   = cpu_req.addr.f.tag;
        line_wr.line.state = MODIFIED;
        line_wr.line.data  = cpu_req.wdata;
        case (state)
            P_WB: begin
                // victim address from the stored tag
                l2_req.wr          = 1'b1;
                l2_req.addr.f.tag  = line.tag;
                l2_req.addr.f.index = cpu_req.addr.f.index;
                l2_req.wdata       = line.data;
            end
            P_FILL: begin
                l2_req.rd            = cpu_req.rd;
                l2_req.rdx           = cpu_req.wr;
                l2_req.addr          = cpu_req.addr;
                l2_req.addr.f.offset = '0;
                line_wr.en           = l2_rsp.data_valid;
                if (cpu_req.rd) begin
                    line_wr.line.state = l2_rsp.shared ? SHARED : EXCLUSIVE;
                    line_wr.line.data  = l2_rsp.rdata;
                end
            end
            P_INV: begin
                l2_req.inv           = 1'b1;
                l2_req.addr          = cpu_req.addr;
                l2_req.addr.f.offset = '0;
                line_wr.en           = all_invalidation_done;
            end
            P_WRITE: line_wr.en = 1'b1;
            default: ;
        endcase
    end

    // ========================================
    // FSM and CPU response
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= P_IDLE;
            cpu_rsp.rd_done <= 1'b0;
            cpu_rsp.wr_done <= 1'b0;
        end else begin
            cpu_rsp.rd_done <= 1'b0;
            cpu_rsp.wr_done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (cpu_req.rd && hit) begin
                        cpu_rsp.rd_done <= 1'b1;
                        cpu_rsp.rdata   <= line.data;
                        state           <= P_DONE;
                    end else if (cpu_req.rd || cpu_req.wr) begin
                        state <= P_REQ;
                    end
                end
                P_REQ: begin
                    // line is stable once the grant is held
                    if (bus_gnt) begin
                        if (hit && line.state == SHARED) begin
                            state <= P_INV;
                        end else if (hit) begin
                            cpu_rsp.wr_done <= 1'b1;
                            state           <= P_WRITE;
                        end else if (line.state == MODIFIED) begin
                            state <= P_WB;
                        end else begin
                            state <= P_FILL;
                        end
                    end
                end
                P_WB: if (l2_rsp.wr_done) state <= P_FILL;
                P_FILL: begin
                    if (l2_rsp.data_valid) begin
                        cpu_rsp.rd_done <= cpu_req.rd;
                        cpu_rsp.wr_done <= cpu_req.wr;
                        cpu_rsp.rdata   <= l2_rsp.rdata;
                        state           <= P_DONE;
                    end
                end
                P_INV: begin
                    if (all_invalidation_done) begin
                        cpu_rsp.wr_done <= 1'b1;
                        state           <= P_DONE;
                    end
                end
                // one guard cycle while the CPU drops its request
                P_WRITE: state <= P_IDLE;
                P_DONE:  state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

endmodule

//--- l1_snoop_ctrl.sv
`timescale 1ns/1ps

module l1_snoop_ctrl
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  snoop_req_t snoop_req,
    output snoop_rsp_t snoop_rsp,
    input  l1_line_t   line,
    output logic       bus_req,
    input  logic       bus_gnt,
    output l2_req_t    l2_req,
    input  l2_rsp_t    l2_rsp,
    output line_wr_t   line_wr
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_FLUSH, S_DONE} snoop_state_e;

    snoop_state_e state;
    logic         hit;
    logic         need_flush;

    assign hit        = (line.tag == snoop_req.addr.f.tag) && (line.state != INVALID);
    assign need_flush = hit && (line.state == MODIFIED) && (snoop_req.rd || snoop_req.rdx);
    assign bus_req    = (state == S_REQ) || (state == S_FLUSH);

    always_comb begin
        l2_req             = '0;
        line_wr            = '0;
        line_wr.index      = snoop_req.addr.f.index;
        line_wr.line       = line;
        // rd downgrades, rdx and inv drop the line
        line_wr.line.state = snoop_req.rd ? SHARED : INVALID;
        if (state == S_REQ) begin
            line_wr.en = bus_gnt && hit && !need_flush;
        end else if (state == S_FLUSH) begin
            l2_req.wr           = 1'b1;
            l2_req.addr.f.tag   = line.tag;
            l2_req.addr.f.index = snoop_req.addr.f.index;
            l2_req.wdata        = line.data;
            line_wr.en          = l2_rsp.wr_done;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            snoop_rsp <= '0;
        end else begin
            snoop_rsp <= '0;
            case (state)
                S_IDLE: if (snoop_req.rd || snoop_req.rdx || snoop_req.inv) state <= S_REQ;
                S_REQ: begin
                    if (bus_gnt && need_flush) begin
                        state <= S_FLUSH;
                    end else if (bus_gnt) begin
                        snoop_rsp.done         <= 1'b1;
                        snoop_rsp.cp_in_cache  <= hit;
                        snoop_rsp.shared_local <= hit && (snoop_req.rd || snoop_req.inv);
                        state                  <= S_DONE;
                    end
                end
                S_FLUSH: begin
                    if (l2_rsp.wr_done) begin
                        snoop_rsp.done         <= 1'b1;
                        snoop_rsp.cp_in_cache  <= 1'b1;
                        snoop_rsp.shared_local <= snoop_req.rd;
                        state                  <= S_DONE;
                    end
                end
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- l2_bus_arbiter.sv
`timescale 1ns/1ps

module l2_bus_arbiter
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     proc_bus_req,
    input  logic     snoop_bus_req,
    output logic     proc_gnt,
    output logic     snoop_gnt,
    input  l2_req_t  proc_l2_req,
    input  l2_req_t  snoop_l2_req,
    output l2_req_t  l2_req,
    input  line_wr_t proc_line_wr,
    input  line_wr_t snoop_line_wr,
    output line_wr_t line_wr
);

    typedef enum logic [1:0] {OWN_NONE, OWN_PROC, OWN_SNOOP} owner_e;

    owner_e owner;

    // snoop side wins a tie and a grant is held while requested
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_PROC:  if (!proc_bus_req) owner <= snoop_bus_req ? OWN_SNOOP : OWN_NONE;
                OWN_SNOOP: if (!snoop_bus_req) owner <= proc_bus_req ? OWN_PROC : OWN_NONE;
                default: begin
                    if (snoop_bus_req) owner <= OWN_SNOOP;
                    else if (proc_bus_req) owner <= OWN_PROC;
                end
            endcase
        end
    end

    assign proc_gnt  = (owner == OWN_PROC);
    assign snoop_gnt = (owner == OWN_SNOOP);
    assign l2_req    = proc_gnt ? proc_l2_req : (snoop_gnt ? snoop_l2_req : '0);
    assign line_wr   = proc_gnt ? proc_line_wr : (snoop_gnt ? snoop_line_wr : '0);

endmodule

//--- l1_dcache_top.sv
`timescale 1ns/1ps

module l1_dcache_top
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_req_t   cpu_req,
    output cpu_rsp_t   cpu_rsp,
    output l2_req_t    l2_req,
    input  l2_rsp_t    l2_rsp,
    input  snoop_req_t snoop_req,
    output snoop_rsp_t snoop_rsp,
    input  logic       all_invalidation_done
);

    l1_line_t proc_line;
    l1_line_t snoop_line;
    logic     proc_bus_req;
    logic     snoop_bus_req;
    logic     proc_gnt;
    logic     snoop_gnt;
    l2_req_t  proc_l2_req;
    l2_req_t  snoop_l2_req;
    line_wr_t proc_line_wr;
    line_wr_t snoop_line_wr;
    line_wr_t store_wr;

    l1_line_store u_store (
        .clk(clk), .rst_n(rst_n),
        .proc_index(cpu_req.addr.f.index), .proc_line(proc_line),
        .snoop_index(snoop_req.addr.f.index), .snoop_line(snoop_line),
        .wr(store_wr)
    );

    l1_proc_ctrl u_proc (
        .clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .line(proc_line), .bus_req(proc_bus_req), .bus_gnt(proc_gnt),
        .l2_req(proc_l2_req), .l2_rsp(l2_rsp),
        .all_invalidation_done(all_invalidation_done), .line_wr(proc_line_wr)
    );

    l1_snoop_ctrl u_snoop (
        .clk(clk), .rst_n(rst_n), .snoop_req(snoop_req), .snoop_rsp(snoop_rsp),
        .line(snoop_line), .bus_req(snoop_bus_req), .bus_gnt(snoop_gnt),
        .l2_req(snoop_l2_req), .l2_rsp(l2_rsp), .line_wr(snoop_line_wr)
    );

    l2_bus_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .proc_bus_req(proc_bus_req), .snoop_bus_req(snoop_bus_req),
        .proc_gnt(proc_gnt), .snoop_gnt(snoop_gnt),
        .proc_l2_req(proc_l2_req), .snoop_l2_req(snoop_l2_req), .l2_req(l2_req),
        .proc_line_wr(proc_line_wr), .snoop_line_wr(snoop_line_wr), .line_wr(store_wr)
    );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- tb_l1_dcache.sv
`timescale 1ns/1ps

`include "l1_consts.svh"

module tb_l1_dcache
    import cache_pkg::*;
    import bus_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 200;
    localparam int ACCESS_LIMIT = 60;
    localparam logic [1:0] K_RD  = 2'd0;
    localparam logic [1:0] K_RDX = 2'd1;
    localparam logic [1:0] K_WR  = 2'd2;
    localparam logic [1:0] K_INV = 2'd3;

    logic       clk;
    logic       rst_n;
    cpu_req_t   cpu_req;
    cpu_rsp_t   cpu_rsp;
    l2_req_t    l2_req;
    l2_rsp_t    l2_rsp;
    snoop_req_t snoop_req;
    snoop_rsp_t snoop_rsp;
    logic       all_invalidation_done;

    logic [31:0]             lfsr = 32'h9d00d047;
    logic                    l2_shared;
    logic [`L1_ADDR_WID-1:0] stored_addr [$];
    logic [`L1_DATA_WID-1:0] stored_data [$];
    logic [1:0]              log_kind [$];
    logic [`L1_ADDR_WID-1:0] log_addr [$];
    logic [`L1_DATA_WID-1:0] log_data [$];
    string                   cur_test;
    int                      error_count;
    int                      errors_start;
    int                      tests_passed;
    int                      tests_failed;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    l1_dcache_top UUT (
        .clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .l2_req(l2_req), .l2_rsp(l2_rsp), .snoop_req(snoop_req), .snoop_rsp(snoop_rsp),
        .all_invalidation_done(all_invalidation_done)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // latest stored word wins over the inverted address
    function automatic logic [`L1_DATA_WID-1:0] l2_read(input logic [`L1_ADDR_WID-1:0] addr);
        logic [`L1_DATA_WID-1:0] data;
        data = ~addr;
        foreach (stored_addr[i]) begin
            if (stored_addr[i] == addr) data = stored_data[i];
        end
        return data;
    endfunction

    task automatic log_request(input logic [1:0] kind, input logic [`L1_ADDR_WID-1:0] addr,
                               input logic [`L1_DATA_WID-1:0] data);
        log_kind.push_back(kind);
        log_addr.push_back(addr);
        log_data.push_back(data);
    endtask

    task automatic clear_log();
        log_kind.delete();
        log_addr.delete();
        log_data.delete();
    endtask

    // ========================================
    // level-2 model
    // ========================================
    initial begin : l2_model
        int      delay;
        logic    inv_seen;
        l2_req_t req;
        inv_seen = 1'b0;
        l2_rsp   = '0;
        forever begin
            @(negedge clk);
            req = l2_req;
            if (req.inv && !inv_seen) log_request(K_INV, req.addr.raw, '0);
            inv_seen = req.inv;
            if (req.rd || req.rdx || req.wr) begin
                log_request(req.wr ? K_WR : (req.rdx ? K_RDX : K_RD), req.addr.raw, req.wdata);
                // 1 to 4 cycles of latency
                delay = 1;
                if (lfsr_bit()) delay += 2;
                if (lfsr_bit()) delay += 1;
                repeat (delay) @(posedge clk);
                #1;
                if (req.wr) begin
                    stored_addr.push_back(req.addr.raw);
                    stored_data.push_back(req.wdata);
                    l2_rsp.wr_done = 1'b1;
                end else begin
                    l2_rsp.data_valid = 1'b1;
                    l2_rsp.shared     = l2_shared;
                    l2_rsp.rdata      = l2_read(req.addr.raw);
                end
                @(posedge clk);
                #1;
                l2_rsp = '0;
            end
        end
    end

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        error_count++;
    endtask

    task automatic fail_msg(input string what);
        $display("ERROR in %s: %s", cur_test, what);
        error_count++;
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        errors_start = error_count;
        clear_log();
    endtask

    task automatic end_test();
        if (error_count == errors_start) begin
            $display("test %s: ok", cur_test);
            tests_passed++;
        end else begin
            $display("test %s: failed", cur_test);
            tests_failed++;
        end
    endtask

    task automatic check_request(input int idx, input logic [1:0] kind,
                                 input logic [`L1_ADDR_WID-1:0] addr);
        if (idx >= log_kind.size()) begin
            fail_msg("an expected level-2 request never appeared");
        end else begin
            if (log_kind[idx] !== kind) fail_value("request kind", kind, log_kind[idx]);
            if (log_addr[idx] !== addr) fail_value("request address", addr, log_addr[idx]);
        end
    endtask

    // ========================================
    // CPU and snoop drivers
    // ========================================
    task automatic start_access(input logic is_wr, input logic [`L1_ADDR_WID-1:0] addr,
                                input logic [`L1_DATA_WID-1:0] wdata);
        @(posedge clk);
        #1;
        cpu_req.rd       = !is_wr;
        cpu_req.wr       = is_wr;
        cpu_req.addr.raw = addr;
        cpu_req.wdata    = wdata;
    endtask

    // counts rising edges until the done pulse, then drops the request
    task automatic finish_access(output logic [`L1_DATA_WID-1:0] rdata, output int cycles);
        logic done;
        logic wrong;
        done   = 1'b0;
        wrong  = 1'b0;
        cycles = 0;
        while (!done && !wrong && cycles < ACCESS_LIMIT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            done  = cpu_req.wr ? cpu_rsp.wr_done : cpu_rsp.rd_done;
            wrong = cpu_req.wr ? cpu_rsp.rd_done : cpu_rsp.wr_done;
        end
        rdata = cpu_rsp.rdata;
        if (wrong) fail_msg("the CPU access got the done pulse of the other kind");
        else if (!done) fail_msg("the CPU access never got its done pulse");
        @(posedge clk);
        #1;
        cpu_req = '0;
    endtask

    task automatic cpu_access(input logic is_wr, input logic [`L1_ADDR_WID-1:0] addr,
                              input logic [`L1_DATA_WID-1:0] wdata,
                              output logic [`L1_DATA_WID-1:0] rdata, output int cycles);
        start_access(is_wr, addr, wdata);
        finish_access(rdata, cycles);
    endtask

    // write to a Shared line that is held back until the other cores acknowledge
    task automatic upgrade_write(input logic [`L1_ADDR_WID-1:0] addr,
                                 input logic [`L1_DATA_WID-1:0] wdata);
        logic [`L1_DATA_WID-1:0] rdata;
        int                      cycles;
        start_access(1'b1, addr, wdata);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!l2_req.inv && cycles < ACCESS_LIMIT);
        if (!l2_req.inv) fail_msg("no invalidate appeared on the level-2 bus");
        else if (l2_req.addr.raw !== addr) fail_value("inv address", addr, l2_req.addr.raw);
        repeat (3) begin
            @(negedge clk);
            if (cpu_rsp.wr_done) fail_msg("wr_done came before all_invalidation_done");
        end
        @(posedge clk);
        #1;
        all_invalidation_done = 1'b1;
        all_invalidation_done <= #(CLK_PERIOD) 1'b0;
        finish_access(rdata, cycles);
    endtask

    task automatic snoop_access(input logic [1:0] kind, input logic [`L1_ADDR_WID-1:0] addr,
                                output snoop_rsp_t rsp);
        int cycles;
        @(posedge clk);
        #1;
        snoop_req.rd       = (kind == K_RD);
        snoop_req.rdx      = (kind == K_RDX);
        snoop_req.inv      = (kind == K_INV);
        snoop_req.addr.raw = addr;
        cycles = 0;
        rsp    = '0;
        while (!rsp.done && cycles < ACCESS_LIMIT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            rsp = snoop_rsp;
        end
        if (!rsp.done) fail_msg("the snoop never got its done pulse");
        @(posedge clk);
        #1;
        snoop_req = '0;
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic read_miss_then_hit();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          cycles;
        addr = 32'h0000_1040;
        begin_test("read_miss_then_hit");
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (rdata !== ~addr) fail_value("fill data", ~addr, rdata);
        if (log_kind.size() != 1) fail_value("level-2 requests on miss", 1, log_kind.size());
        check_request(0, K_RD, addr);
        clear_log();
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (rdata !== ~addr) fail_value("hit data", ~addr, rdata);
        if (cycles != 1) fail_value("read hit cycles", 1, cycles);
        if (log_kind.size() != 0) fail_value("level-2 requests on hit", 0, log_kind.size());
        end_test();
    endtask

    task automatic write_miss_then_hit();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          cycles;
        addr = 32'h0000_2084;
        begin_test("write_miss_then_hit");
        cpu_access(1'b1, addr, 32'hcafe_0001, rdata, cycles);
        if (log_kind.size() != 1) fail_value("level-2 requests on miss", 1, log_kind.size());
        check_request(0, K_RDX, addr);
        clear_log();
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (rdata !== 32'hcafe_0001) fail_value("read after write", 32'hcafe_0001, rdata);
        cpu_access(1'b1, addr, 32'hcafe_0002, rdata, cycles);
        if (cycles != 3) fail_value("write hit cycles", 3, cycles);
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (rdata !== 32'hcafe_0002) fail_value("read after write hit", 32'hcafe_0002, rdata);
        if (log_kind.size() != 0) fail_value("level-2 requests on hits", 0, log_kind.size());
        end_test();
    endtask

    task automatic shared_write_upgrade();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          cycles;
        addr = 32'h0000_3008;
        begin_test("shared_write_upgrade");
        l2_shared = 1'b1;
        cpu_access(1'b0, addr, '0, rdata, cycles);
        l2_shared = 1'b0;
        upgrade_write(addr, 32'h5eed_0003);
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (rdata !== 32'h5eed_0003) fail_value("read after upgrade", 32'h5eed_0003, rdata);
        if (log_kind.size() != 2) fail_value("level-2 requests", 2, log_kind.size());
        check_request(0, K_RD, addr);
        check_request(1, K_INV, addr);
        end_test();
    endtask

    task automatic evict_modified_line();
        logic [31:0] victim;
        logic [31:0] addr;
        logic [31:0] rdata;
        int          cycles;
        victim = 32'h0000_4014;
        addr   = 32'h0000_6014;
        begin_test("evict_modified_line");
        cpu_access(1'b1, victim, 32'hd1e7_0004, rdata, cycles);
        clear_log();
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (rdata !== ~addr) fail_value("fill data", ~addr, rdata);
        if (log_kind.size() != 2) fail_value("level-2 requests", 2, log_kind.size());
        check_request(0, K_WR, victim);
        check_request(1, K_RD, addr);
        if (log_data.size() > 0 && log_data[0] !== 32'hd1e7_0004)
            fail_value("write-back data", 32'hd1e7_0004, log_data[0]);
        // victim now lives in level 2
        cpu_access(1'b0, victim, '0, rdata, cycles);
        if (rdata !== 32'hd1e7_0004) fail_value("victim refill", 32'hd1e7_0004, rdata);
        end_test();
    endtask

    task automatic snoop_rd_of_modified();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          cycles;
        snoop_rsp_t  rsp;
        addr = 32'h0000_7028;
        begin_test("snoop_rd_of_modified");
        cpu_access(1'b1, addr, 32'hf00d_0005, rdata, cycles);
        clear_log();
        snoop_access(K_RD, addr, rsp);
        if (!rsp.cp_in_cache) fail_msg("cp_in_cache was low for a cached line");
        if (!rsp.shared_local) fail_msg("shared_local was low after a snooped rd");
        if (log_kind.size() != 1) fail_value("level-2 requests", 1, log_kind.size());
        check_request(0, K_WR, addr);
        if (log_data.size() > 0 && log_data[0] !== 32'hf00d_0005)
            fail_value("flush data", 32'hf00d_0005, log_data[0]);
        clear_log();
        upgrade_write(addr, 32'hf00d_0015);
        check_request(0, K_INV, addr);
        end_test();
    endtask

    task automatic snoop_rdx_and_inv();
        logic [31:0] addr;
        logic [31:0] missing;
        logic [31:0] rdata;
        int          cycles;
        snoop_rsp_t  rsp;
        addr    = 32'h0000_8030;
        missing = 32'h0000_9034;
        begin_test("snoop_rdx_and_inv");
        cpu_access(1'b0, addr, '0, rdata, cycles);
        snoop_access(K_RDX, addr, rsp);
        if (!rsp.cp_in_cache) fail_msg("cp_in_cache was low for a cached line");
        if (rsp.shared_local) fail_msg("shared_local was high after a snooped rdx");
        clear_log();
        cpu_access(1'b0, addr, '0, rdata, cycles);
        if (log_kind.size() != 1) fail_value("level-2 requests after rdx", 1, log_kind.size());
        check_request(0, K_RD, addr);
        snoop_access(K_INV, missing, rsp);
        if (rsp.cp_in_cache) fail_msg("cp_in_cache was high for a missing line");
        if (rsp.shared_local) fail_msg("shared_local was high for a missing line");
        end_test();
    endtask

    initial begin
        cpu_req               = '0;
        snoop_req             = '0;
        all_invalidation_done = 1'b0;
        l2_shared             = 1'b0;
        error_count           = 0;
        tests_passed          = 0;
        tests_failed          = 0;
        @(posedge rst_n);
        read_miss_then_hit();
        write_miss_then_hit();
        shared_write_upgrade();
        evict_modified_line();
        snoop_rd_of_modified();
        snoop_rdx_and_inv();
        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
cache_pkg.sv
bus_pkg.sv
l1_line_store.sv
l1_proc_ctrl.sv
l1_snoop_ctrl.sv
l2_bus_arbiter.sv
l1_dcache_top.sv
tb_clk_gen.sv
tb_l1_dcache.sv

//--- Bender.yml
package:
  name: l1_dcache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - bus_pkg.sv
      - l1_line_store.sv
      - l1_proc_ctrl.sv
      - l1_snoop_ctrl.sv
      - l2_bus_arbiter.sv
      - l1_dcache_top.sv
      - target: test
        files:
          - tb_clk_gen.sv
          - tb_l1_dcache.sv
